// File: include/axil_macros.svh
`ifndef AXIL_MACROS_SVH
`define AXIL_MACROS_SVH

// Byte address width of every AXI-Lite port
`define AXIL_ADDR_WIDTH 12

// Data bus width, strobes follow as one bit per byte
`define AXIL_DATA_WIDTH 32

// Outstanding transactions per direction allowed through the pause gate
`define AXIL_MAX_TRANS 3

`endif

// File: logic/axil_pkg.sv
`default_nettype none

`include "axil_macros.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [2:0]                    prot_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Everything the manager drives
    typedef struct packed {
        addr_t aw_addr;
        prot_t aw_prot;
        logic  aw_valid;
        data_t w_data;
        strb_t w_strb;
        logic  w_valid;
        logic  b_ready;
        addr_t ar_addr;
        prot_t ar_prot;
        logic  ar_valid;
        logic  r_ready;
    } axil_req_t;

    // Everything the target drives
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        axil_resp_t b_resp;
        logic       b_valid;
        logic       ar_ready;
        data_t      r_data;
        axil_resp_t r_resp;
        logic       r_valid;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: logic/regmap_pkg.sv
`default_nettype none

`include "axil_macros.svh"

package regmap_pkg;

    typedef logic [2:0] reg_index_t;

    localparam int unsigned REG_COUNT        = 8;
    localparam int unsigned REG_INDEX_LSB    = 2;
    localparam int unsigned REG_WINDOW_BYTES = REG_COUNT * (`AXIL_DATA_WIDTH / 8);

    // Word index inside the window, byte offset dropped
    function automatic reg_index_t reg_index(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
        return addr[REG_INDEX_LSB +: $bits(reg_index_t)];
    endfunction

    function automatic logic reg_mapped(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
        return addr < REG_WINDOW_BYTES;
    endfunction

endpackage

`default_nettype wire

// File: logic/axil_pause_gate.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_macros.svh"

module axil_pause_gate
    import axil_pkg::*;
#(
    parameter int unsigned max_trans = `AXIL_MAX_TRANS
) (
    input  logic      seq,
    input  logic      arst_n,

    input  logic      pause_req,
    output logic      pause_ack,

    input  axil_req_t slv_req,
    output axil_rsp_t slv_rsp,

    output axil_req_t mst_req,
    input  axil_rsp_t mst_rsp
);

    localparam int unsigned cnt_width = $clog2(max_trans) + 1;

    typedef logic [cnt_width-1:0] cnt_t;

    cnt_t aw_cnt;
    cnt_t w_cnt;
    cnt_t ar_cnt;
    cnt_t aw_cnt_nxt;
    cnt_t w_cnt_nxt;
    cnt_t ar_cnt_nxt;

    logic aw_en;
    logic w_en;
    logic b_en;
    logic ar_en;
    logic r_en;

    logic aw_open;
    logic w_open;
    logic ar_open;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;

    logic hold;

    // A direction at its limit waits for a response to retire one
    assign aw_open = aw_en && (aw_cnt != cnt_t'(max_trans));
    assign w_open  = w_en  && (w_cnt  != cnt_t'(max_trans));
    assign ar_open = ar_en && (ar_cnt != cnt_t'(max_trans));

    // Payloads pass straight through, only handshakes are gated
    always_comb begin
        mst_req          = slv_req;
        mst_req.aw_valid = aw_open && slv_req.aw_valid;
        mst_req.w_valid  = w_open  && slv_req.w_valid;
        mst_req.b_ready  = b_en    && slv_req.b_ready;
        mst_req.ar_valid = ar_open && slv_req.ar_valid;
        mst_req.r_ready  = r_en    && slv_req.r_ready;

        slv_rsp          = mst_rsp;
        slv_rsp.aw_ready = aw_open && mst_rsp.aw_ready;
        slv_rsp.w_ready  = w_open  && mst_rsp.w_ready;
        slv_rsp.b_valid  = b_en    && mst_rsp.b_valid;
        slv_rsp.ar_ready = ar_open && mst_rsp.ar_ready;
        slv_rsp.r_valid  = r_en    && mst_rsp.r_valid;
    end

    assign aw_fire = mst_req.aw_valid && mst_rsp.aw_ready;
    assign w_fire  = mst_req.w_valid  && mst_rsp.w_ready;
    assign b_fire  = mst_rsp.b_valid  && mst_req.b_ready;
    assign ar_fire = mst_req.ar_valid && mst_rsp.ar_ready;
    assign r_fire  = mst_rsp.r_valid  && mst_req.r_ready;

    // A B beat retires one address and one data beat
    assign aw_cnt_nxt = aw_cnt + cnt_t'(aw_fire) - cnt_t'(b_fire);
    assign w_cnt_nxt  = w_cnt  + cnt_t'(w_fire)  - cnt_t'(b_fire);
    assign ar_cnt_nxt = ar_cnt + cnt_t'(ar_fire) - cnt_t'(r_fire);

    assign hold = pause_req && pause_ack;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            aw_cnt    <= '0;
            w_cnt     <= '0;
            ar_cnt    <= '0;
            aw_en     <= 1'b0;
            w_en      <= 1'b0;
            b_en      <= 1'b0;
            ar_en     <= 1'b0;
            r_en      <= 1'b0;
            pause_ack <= 1'b1;
        end else if (!hold) begin
            aw_cnt <= aw_cnt_nxt;
            w_cnt  <= w_cnt_nxt;
            ar_cnt <= ar_cnt_nxt;

            if (pause_req) begin
                // Draining, the side that is ahead stops first
                if (aw_cnt_nxt >= w_cnt_nxt) begin
                    aw_en <= 1'b0;
                end
                if (w_cnt_nxt >= aw_cnt_nxt) begin
                    w_en <= 1'b0;
                end
                ar_en <= 1'b0;

                if (aw_cnt_nxt == '0 && w_cnt_nxt == '0) begin
                    b_en <= 1'b0;
                end
                if (ar_cnt_nxt == '0) begin
                    r_en <= 1'b0;
                end

                if (aw_cnt_nxt == '0 && w_cnt_nxt == '0 && ar_cnt_nxt == '0) begin
                    pause_ack <= 1'b1;
                end
            end else begin
                // Resume, also reopens after a withdrawn request
                aw_en     <= 1'b1;
                w_en      <= 1'b1;
                b_en      <= 1'b1;
                ar_en     <= 1'b1;
                r_en      <= 1'b1;
                pause_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/axil_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_macros.svh"

module axil_reg_bank
    import axil_pkg::*;
    import regmap_pkg::*;
(
    input  logic      seq,
    input  logic      arst_n,

    input  axil_req_t req,
    output axil_rsp_t rsp
);

    data_t regs [REG_COUNT];

    // Write address and data buffers
    logic  aw_full;
    addr_t aw_addr_q;
    logic  w_full;
    data_t w_data_q;
    strb_t w_strb_q;

    logic       b_valid;
    axil_resp_t b_resp_q;
    logic       r_valid;
    data_t      r_data_q;
    axil_resp_t r_resp_q;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;
    logic write_go;

    logic       wr_mapped;
    reg_index_t wr_index;
    logic       rd_mapped;
    reg_index_t rd_index;

    always_comb begin
        rsp.aw_ready = !aw_full;
        rsp.w_ready  = !w_full;
        rsp.b_resp   = b_resp_q;
        rsp.b_valid  = b_valid;
        rsp.ar_ready = !r_valid;
        rsp.r_data   = r_data_q;
        rsp.r_resp   = r_resp_q;
        rsp.r_valid  = r_valid;
    end

    assign aw_fire = req.aw_valid && rsp.aw_ready;
    assign w_fire  = req.w_valid  && rsp.w_ready;
    assign b_fire  = b_valid      && req.b_ready;
    assign ar_fire = req.ar_valid && rsp.ar_ready;
    assign r_fire  = r_valid      && req.r_ready;

    // Write only once both halves are in and the last B is gone
    assign write_go = aw_full && w_full && !b_valid;

    assign wr_mapped = reg_mapped(aw_addr_q);
    assign wr_index  = reg_index(aw_addr_q);
    assign rd_mapped = reg_mapped(req.ar_addr);
    assign rd_index  = reg_index(req.ar_addr);

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_full <= 1'b1;
            end else if (write_go) begin
                aw_full <= 1'b0;
            end

            if (w_fire) begin
                w_full <= 1'b1;
            end else if (write_go) begin
                w_full <= 1'b0;
            end

            if (write_go) begin
                b_valid <= 1'b1;
            end else if (b_fire) begin
                b_valid <= 1'b0;
            end

            if (ar_fire) begin
                r_valid <= 1'b1;
            end else if (r_fire) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (aw_fire) begin
            aw_addr_q <= req.aw_addr;
        end

        if (w_fire) begin
            w_data_q <= req.w_data;
            w_strb_q <= req.w_strb;
        end

        if (write_go) begin
            if (wr_mapped) begin
                b_resp_q <= RESP_OKAY;
            end else begin
                b_resp_q <= RESP_SLVERR;
            end
        end

        // Unmapped reads give zero data
        if (ar_fire) begin
            if (rd_mapped) begin
                r_data_q <= regs[rd_index];
                r_resp_q <= RESP_OKAY;
            end else begin
                r_data_q <= '0;
                r_resp_q <= RESP_SLVERR;
            end
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_go && wr_mapped) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (w_strb_q[b]) begin
                    regs[wr_index][8*b +: 8] <= w_data_q[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/axil_pause_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_macros.svh"

module axil_pause_top
    import axil_pkg::*;
(
    input  logic      seq,
    input  logic      arst_n,

    input  logic      pause_req,
    output logic      pause_ack,

    input  axil_req_t mgr_req,
    output axil_rsp_t mgr_rsp
);

    // Between gate and register bank
    axil_req_t bank_req;
    axil_rsp_t bank_rsp;

    axil_pause_gate #(
        .max_trans (`AXIL_MAX_TRANS)
    ) gate0 (
        .seq       (seq),
        .arst_n    (arst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .slv_req   (mgr_req),
        .slv_rsp   (mgr_rsp),
        .mst_req   (bank_req),
        .mst_rsp   (bank_rsp)
    );

    axil_reg_bank bank0 (
        .seq    (seq),
        .arst_n (arst_n),
        .req    (bank_req),
        .rsp    (bank_rsp)
    );

endmodule

`default_nettype wire

// File: testbench/axil_pause_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_macros.svh"

module axil_pause_checker
    import axil_pkg::*;
#(
    parameter int unsigned max_trans = `AXIL_MAX_TRANS,
    parameter int unsigned cnt_width = $clog2(max_trans) + 1
) (
    input logic                 seq,
    input logic                 arst_n,
    input logic                 pause_req,
    input logic                 pause_ack,
    input axil_req_t            slv_req,
    input axil_rsp_t            slv_rsp,
    input axil_req_t            mst_req,
    input axil_rsp_t            mst_rsp,
    input logic [cnt_width-1:0] aw_cnt,
    input logic [cnt_width-1:0] w_cnt,
    input logic [cnt_width-1:0] ar_cnt
);

    int failures = 0;

    // Held pause keeps every channel toward the bank silent
    assert property (@(posedge seq) disable iff (!arst_n)
        pause_req && pause_ack |-> !(mst_req.aw_valid || mst_req.w_valid || mst_req.ar_valid
                                     || mst_rsp.b_valid || mst_rsp.r_valid))
    else begin
        $error("valid raised toward the bank during a held pause");
        failures++;
    end

    assert property (@(posedge seq) disable iff (!arst_n)
        slv_rsp.b_valid && !slv_req.b_ready |=> slv_rsp.b_valid)
    else begin
        $error("b_valid dropped before b_ready");
        failures++;
    end

    assert property (@(posedge seq) disable iff (!arst_n)
        slv_rsp.r_valid && !slv_req.r_ready |=> slv_rsp.r_valid)
    else begin
        $error("r_valid dropped before r_ready");
        failures++;
    end

    assert property (@(posedge seq) disable iff (!arst_n)
        aw_cnt <= max_trans && w_cnt <= max_trans && ar_cnt <= max_trans)
    else begin
        $error("outstanding count above limit");
        failures++;
    end

endmodule

bind axil_pause_gate axil_pause_checker #(
    .max_trans (max_trans)
) checker0 (
    .seq       (seq),
    .arst_n    (arst_n),
    .pause_req (pause_req),
    .pause_ack (pause_ack),
    .slv_req   (slv_req),
    .slv_rsp   (slv_rsp),
    .mst_req   (mst_req),
    .mst_rsp   (mst_rsp),
    .aw_cnt    (aw_cnt),
    .w_cnt     (w_cnt),
    .ar_cnt    (ar_cnt)
);

`default_nettype wire

// File: testbench/tb_axil_pause_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_pause_top
    import axil_pkg::*;
    import regmap_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    // 43 directed and 60 random transactions
    localparam int N_TRANS      = 103;

    typedef enum logic [1:0] {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

    typedef struct packed {
        data_t      data;
        axil_resp_t resp;
    } rd_exp_t;

    logic      seq;
    logic      arst_n;
    logic      pause_req;
    logic      pause_ack;
    axil_req_t mgr_req;
    axil_rsp_t mgr_rsp;

    data_t       model [REG_COUNT];
    axil_resp_t  exp_b [$];
    rd_exp_t     exp_r [$];
    int          errors     = 0;
    int          b_issued   = 0;
    int          b_done     = 0;
    int          r_issued   = 0;
    int          r_done     = 0;
    int          aw_taken   = 0;
    int          ar_taken   = 0;
    int          pause_left = 0;
    int unsigned lcg_state  = 8;
    logic        rand_pause = 1'b0;
    ready_mode_t ready_mode = READY_HIGH;

    axil_pause_top dut0 (
        .seq       (seq),
        .arst_n    (arst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .mgr_req   (mgr_req),
        .mgr_rsp   (mgr_rsp)
    );

    initial begin
        seq = 1'b0;
        forever #(CLK_PERIOD / 2) seq = ~seq;
    end

    function automatic int unsigned lcg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic data_t rand_data();
        return {16'(lcg()), 16'(lcg())};
    endfunction

    // Mostly inside the window and sometimes far outside
    function automatic addr_t rand_addr();
        if (lcg() % 8 == 0) begin
            return addr_t'(REG_WINDOW_BYTES + (lcg() % 1000) * 4);
        end
        return addr_t'((lcg() % REG_COUNT) * 4);
    endfunction

    // Register model indexed by address bits 4 to 2
    function automatic axil_resp_t model_write(input addr_t addr, input data_t data,
                                               input strb_t strb);
        if (addr >= REG_WINDOW_BYTES) begin
            return RESP_SLVERR;
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model[addr[4:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        return RESP_OKAY;
    endfunction

    function automatic rd_exp_t expect_read(input addr_t addr);
        rd_exp_t e;
        e.data = '0;
        e.resp = RESP_SLVERR;
        if (addr < REG_WINDOW_BYTES) begin
            e.data = model[addr[4:2]];
            e.resp = RESP_OKAY;
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // One clock with handshakes sampled mid-cycle and inputs driven 5 ns after the edge
    task automatic cycle();
        logic aw_hit;
        logic w_hit;
        logic ar_hit;
        @(negedge seq);
        aw_hit = mgr_req.aw_valid && mgr_rsp.aw_ready;
        w_hit  = mgr_req.w_valid && mgr_rsp.w_ready;
        ar_hit = mgr_req.ar_valid && mgr_rsp.ar_ready;
        @(posedge seq);
        #5;
        if (aw_hit) begin
            mgr_req.aw_valid = 1'b0;
            aw_taken++;
        end
        if (w_hit) begin
            mgr_req.w_valid = 1'b0;
        end
        if (ar_hit) begin
            mgr_req.ar_valid = 1'b0;
            ar_taken++;
        end
        mgr_req.b_ready = (ready_mode == READY_HIGH);
        mgr_req.r_ready = (ready_mode == READY_HIGH);
        if (ready_mode == READY_RANDOM) begin
            mgr_req.b_ready = (lcg() % 3 != 0);
            mgr_req.r_ready = (lcg() % 3 != 0);
        end
        if (rand_pause) begin
            if (pause_left > 0) begin
                pause_left--;
                pause_req = (pause_left > 0);
            end else if (lcg() % 16 == 0) begin
                pause_left = 2 + lcg() % 6;
                pause_req  = 1'b1;
            end
        end
    endtask

    task automatic start_write(input addr_t addr, input data_t data, input strb_t strb);
        exp_b.push_back(model_write(addr, data, strb));
        b_issued++;
        mgr_req.aw_addr  = addr;
        mgr_req.aw_prot  = '0;
        mgr_req.aw_valid = 1'b1;
        mgr_req.w_data   = data;
        mgr_req.w_strb   = strb;
        mgr_req.w_valid  = 1'b1;
    endtask

    task automatic start_read(input addr_t addr);
        exp_r.push_back(expect_read(addr));
        r_issued++;
        mgr_req.ar_addr  = addr;
        mgr_req.ar_prot  = '0;
        mgr_req.ar_valid = 1'b1;
    endtask

    task automatic wait_accept();
        while (mgr_req.aw_valid || mgr_req.w_valid || mgr_req.ar_valid) begin
            cycle();
        end
    endtask

    task automatic wait_responses();
        while (b_done < b_issued || r_done < r_issued) begin
            cycle();
        end
    endtask

    task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb);
        start_write(addr, data, strb);
        wait_accept();
        wait_responses();
    endtask

    task automatic read_reg(input addr_t addr);
        start_read(addr);
        wait_accept();
        wait_responses();
    endtask

    // Compares every B and R beat with the model prediction
    initial begin
        axil_resp_t b_exp;
        rd_exp_t    r_exp;
        forever begin
            @(negedge seq);
            if (arst_n && mgr_rsp.b_valid && mgr_req.b_ready) begin
                b_done++;
                assert (exp_b.size() > 0) else begin
                    errors++;
                    $display("Error at %0t: B response with no write outstanding", $time);
                end
                if (exp_b.size() > 0) begin
                    b_exp = exp_b.pop_front();
                    check_value("b_resp", 32'(b_exp), 32'(mgr_rsp.b_resp));
                end
            end
            if (arst_n && mgr_rsp.r_valid && mgr_req.r_ready) begin
                r_done++;
                assert (exp_r.size() > 0) else begin
                    errors++;
                    $display("Error at %0t: R response with no read outstanding", $time);
                end
                if (exp_r.size() > 0) begin
                    r_exp = exp_r.pop_front();
                    check_value("r_data", r_exp.data, mgr_rsp.r_data);
                    check_value("r_resp", 32'(r_exp.resp), 32'(mgr_rsp.r_resp));
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + N_TRANS * 40));
        $display("Timeout: run did not finish in time, %0d errors so far", errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int accepted;
        mgr_req   = '0;
        pause_req = 1'b1;
        arst_n    = 1'b0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge seq);
        #5;
        arst_n = 1'b1;

        // Starts paused so the offered write waits for resume
        start_write(12'h01C, 32'h1234_5678, 4'hF);
        repeat (4) begin
            cycle();
            check_value("pause_ack", 32'd1, 32'(pause_ack));
            check_value("aw_ready", 32'd0, 32'(mgr_rsp.aw_ready));
            check_value("w_ready", 32'd0, 32'(mgr_rsp.w_ready));
            check_value("ar_ready", 32'd0, 32'(mgr_rsp.ar_ready));
        end
        pause_req = 1'b0;
        cycle();
        check_value("pause_ack", 32'd0, 32'(pause_ack));
        wait_accept();
        wait_responses();

        for (int i = 0; i < REG_COUNT; i++) begin
            write_reg(addr_t'(i * 4), rand_data(), 4'hF);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            write_reg(addr_t'(i * 4), rand_data(), strb_t'(lcg() % 14 + 1));
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            read_reg(addr_t'(i * 4));
        end

        // Unmapped space
        write_reg(12'h020, rand_data(), 4'hF);
        write_reg(12'h400, rand_data(), 4'hF);
        write_reg(12'hFFC, rand_data(), 4'h3);
        read_reg(12'h020);
        read_reg(12'h7F0);
        read_reg(12'hFFC);
        for (int i = 0; i < REG_COUNT; i++) begin
            read_reg(addr_t'(i * 4));
        end

        // Pause with a write and a read stuck behind back-pressure
        ready_mode      = READY_LOW;
        mgr_req.b_ready = 1'b0;
        mgr_req.r_ready = 1'b0;
        start_write(12'h004, 32'hA5A5_0001, 4'hF);
        start_read(12'h008);
        wait_accept();
        pause_req = 1'b1;
        cycle();
        start_write(12'h00C, 32'h5A5A_0002, 4'hF);
        start_read(12'h010);
        accepted = aw_taken + ar_taken;
        repeat (6) begin
            cycle();
            check_value("pause_ack", 32'd0, 32'(pause_ack));
        end
        ready_mode = READY_HIGH;
        while (!pause_ack) begin
            cycle();
        end
        assert (b_done == b_issued - 1 && r_done == r_issued - 1) else begin
            errors++;
            $display("Error at %0t: pause acknowledged before responses were taken", $time);
        end
        repeat (4) cycle();
        assert (aw_taken + ar_taken == accepted) else begin
            errors++;
            $display("Error at %0t: address beat accepted during the pause", $time);
        end
        pause_req = 1'b0;
        wait_accept();
        wait_responses();

        ready_mode = READY_RANDOM;
        rand_pause = 1'b1;
        repeat (60) begin
            if (lcg() % 2 == 0) begin
                write_reg(rand_addr(), rand_data(), strb_t'(lcg() % 16));
            end else begin
                read_reg(rand_addr());
            end
        end
        rand_pause = 1'b0;
        pause_left = 0;
        pause_req  = 1'b0;
        repeat (2) cycle();

        errors += dut0.gate0.checker0.failures;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: axil_pause.f
+incdir+include
logic/axil_pkg.sv
logic/regmap_pkg.sv
logic/axil_pause_gate.sv
logic/axil_reg_bank.sv
logic/axil_pause_top.sv
testbench/axil_pause_checker.sv
testbench/tb_axil_pause_top.sv
